// ==== compile.f ====
superscalar_pkg.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
superscalar_core.sv
superscalar_core_properties.sv
superscalar_core_tb.sv

// ==== decode_stage.sv ====
// decode stage: captures a fetch group, decodes all three lanes
// and reads their source operands from the register file

module decode_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           fetch_valid,
	input  superscalar_pkg::fetch_group_t  fetch_group,
	input  superscalar_pkg::word_t         read_data [superscalar_pkg::READ_PORTS],
	output superscalar_pkg::reg_idx_t      read_idx  [superscalar_pkg::READ_PORTS],
	output superscalar_pkg::decoded_lane_t decoded   [superscalar_pkg::WAYS],
	output logic                           decoded_valid
);

	superscalar_pkg::fetch_group_t group_q;
	logic                          group_valid;

	// group register, payload held while no strobe
	always_ff @(posedge clock) begin
		if (!reset) begin
			group_valid <= 1'b0;
		end else begin
			group_valid <= fetch_valid;
			if (fetch_valid) begin
				group_q <= fetch_group;
			end
		end
	end

	assign decoded_valid = group_valid;

	////////////////////////////////////////////////////////////////////////////
	// lane decoders
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		superscalar_pkg::inst_t inst;
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			// masked lanes decode as a nop so they raise no flags
			inst = group_q.mask[i] ? group_q.inst[i] : superscalar_pkg::INST_NOP;

			decoded[i]        = '0;
			decoded[i].valid  = group_valid & group_q.mask[i];
			decoded[i].dest   = inst[11:7];
			decoded[i].rs1    = inst[19:15];
			decoded[i].alu_op = superscalar_pkg::ALU_ADD;

			case (inst[6:0])
				superscalar_pkg::OPCODE_OP: begin
					decoded[i].rs2         = inst[24:20];
					decoded[i].writes_dest = 1'b1;
					case ({inst[31:25], inst[14:12]})
						{superscalar_pkg::FUNCT7_BASE, superscalar_pkg::FUNCT3_ADD_SUB}:
							decoded[i].alu_op = superscalar_pkg::ALU_ADD;
						{superscalar_pkg::FUNCT7_SUB, superscalar_pkg::FUNCT3_ADD_SUB}:
							decoded[i].alu_op = superscalar_pkg::ALU_SUB;
						{superscalar_pkg::FUNCT7_BASE, superscalar_pkg::FUNCT3_XOR}:
							decoded[i].alu_op = superscalar_pkg::ALU_XOR;
						{superscalar_pkg::FUNCT7_BASE, superscalar_pkg::FUNCT3_OR}:
							decoded[i].alu_op = superscalar_pkg::ALU_OR;
						{superscalar_pkg::FUNCT7_BASE, superscalar_pkg::FUNCT3_AND}:
							decoded[i].alu_op = superscalar_pkg::ALU_AND;
						default: begin
							decoded[i].illegal     = 1'b1;
							decoded[i].writes_dest = 1'b0;
						end
					endcase
				end
				superscalar_pkg::OPCODE_OP_IMM: begin
					if (inst[14:12] == superscalar_pkg::FUNCT3_ADD_SUB) begin // addi only
						decoded[i].imm         = {{20{inst[31]}}, inst[31:20]};
						decoded[i].use_imm     = 1'b1;
						decoded[i].writes_dest = 1'b1;
					end else begin
						decoded[i].illegal = 1'b1;
					end
				end
				superscalar_pkg::OPCODE_LUI: begin
					decoded[i].rs1         = '0;
					decoded[i].imm         = {inst[31:12], 12'b0};
					decoded[i].use_imm     = 1'b1;
					decoded[i].alu_op      = superscalar_pkg::ALU_PASS_B;
					decoded[i].writes_dest = 1'b1;
				end
				superscalar_pkg::OPCODE_SYSTEM: begin
					decoded[i].rs1     = '0;
					decoded[i].halt    = (inst == superscalar_pkg::INST_WFI);
					decoded[i].illegal = (inst != superscalar_pkg::INST_WFI);
				end
				default: begin
					decoded[i].rs1     = '0;
					decoded[i].illegal = 1'b1;
				end
			endcase

			if (decoded[i].dest == '0) begin
				decoded[i].writes_dest = 1'b0; // x0 is never a destination
			end

			// rs1 on even ports, rs2 on odd
			read_idx[2*i]          = decoded[i].rs1;
			read_idx[2*i+1]        = decoded[i].rs2;
			decoded[i].rs1_value   = read_data[2*i];
			decoded[i].rs2_value   = read_data[2*i+1];
		end
	end

endmodule

// ==== execute_stage.sv ====
// execute stage: holds the decoded group, forwards operands from
// older lanes and from the retiring group, then runs the lane ALUs

module execute_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  superscalar_pkg::decoded_lane_t decoded  [superscalar_pkg::WAYS],
	input  logic                           decoded_valid,
	input  superscalar_pkg::result_lane_t  retire   [superscalar_pkg::WAYS],
	output superscalar_pkg::result_lane_t  executed [superscalar_pkg::WAYS],
	output logic                           executed_valid
);

	superscalar_pkg::decoded_lane_t ex_q [superscalar_pkg::WAYS];
	logic                           ex_valid;

	superscalar_pkg::word_t opnd_a  [superscalar_pkg::WAYS];
	superscalar_pkg::word_t opnd_b  [superscalar_pkg::WAYS];
	superscalar_pkg::word_t alu_out [superscalar_pkg::WAYS];

	function automatic superscalar_pkg::word_t alu(
		input superscalar_pkg::alu_op_t op,
		input superscalar_pkg::word_t   a,
		input superscalar_pkg::word_t   b
	);
		case (op)
			superscalar_pkg::ALU_SUB:    return a - b;
			superscalar_pkg::ALU_AND:    return a & b;
			superscalar_pkg::ALU_OR:     return a | b;
			superscalar_pkg::ALU_XOR:    return a ^ b;
			superscalar_pkg::ALU_PASS_B: return b;
			default:                     return a + b;
		endcase
	endfunction

	always_ff @(posedge clock) begin
		if (!reset) begin
			ex_valid <= 1'b0;
			for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
				ex_q[i].valid <= 1'b0;
			end
		end else begin
			ex_valid <= decoded_valid;
			ex_q     <= decoded;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// forwarding and ALUs
	////////////////////////////////////////////////////////////////////////////

	// lanes are resolved in program order so older results are ready
	always_comb begin
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			opnd_a[i] = ex_q[i].rs1_value; // register file value
			opnd_b[i] = ex_q[i].rs2_value;

			// retiring group, highest lane last so it wins
			for (int j = 0; j < superscalar_pkg::WAYS; j++) begin
				if (retire[j].valid && retire[j].writes_dest) begin
					if (retire[j].dest == ex_q[i].rs1) begin
						opnd_a[i] = retire[j].result;
					end
					if (retire[j].dest == ex_q[i].rs2) begin
						opnd_b[i] = retire[j].result;
					end
				end
			end

			// older lanes of this group override, nearest one last
			for (int j = 0; j < i; j++) begin
				if (ex_q[j].valid && ex_q[j].writes_dest) begin
					if (ex_q[j].dest == ex_q[i].rs1) begin
						opnd_a[i] = alu_out[j];
					end
					if (ex_q[j].dest == ex_q[i].rs2) begin
						opnd_b[i] = alu_out[j];
					end
				end
			end

			if (ex_q[i].use_imm) begin
				opnd_b[i] = ex_q[i].imm;
			end
			alu_out[i] = alu(ex_q[i].alu_op, opnd_a[i], opnd_b[i]);

			executed[i].valid       = ex_q[i].valid;
			executed[i].dest        = ex_q[i].dest;
			executed[i].writes_dest = ex_q[i].writes_dest;
			executed[i].result      = alu_out[i];
			executed[i].halt        = ex_q[i].halt;
			executed[i].illegal     = ex_q[i].illegal;
		end
	end

	assign executed_valid = ex_valid;

endmodule

// ==== register_file.sv ====
// architectural register file, one write port per lane
// reads see same-cycle writes, x0 always reads zero

module register_file (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      write_en   [superscalar_pkg::WAYS],
	input  superscalar_pkg::reg_idx_t write_idx  [superscalar_pkg::WAYS],
	input  superscalar_pkg::word_t    write_data [superscalar_pkg::WAYS],
	input  superscalar_pkg::reg_idx_t read_idx   [superscalar_pkg::READ_PORTS],
	output superscalar_pkg::word_t    read_data  [superscalar_pkg::READ_PORTS]
);

	superscalar_pkg::word_t regs [superscalar_pkg::REG_COUNT];

	// later lanes are younger, so the last write in the loop lands
	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < superscalar_pkg::REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int w = 0; w < superscalar_pkg::WAYS; w++) begin
				if (write_en[w] && write_idx[w] != '0) begin
					regs[write_idx[w]] <= write_data[w];
				end
			end
		end
	end

	// write-through, same lane priority as the array
	always_comb begin
		for (int p = 0; p < superscalar_pkg::READ_PORTS; p++) begin
			read_data[p] = regs[read_idx[p]];
			for (int w = 0; w < superscalar_pkg::WAYS; w++) begin
				if (write_en[w] && write_idx[w] == read_idx[p]) begin
					read_data[p] = write_data[w];
				end
			end
			if (read_idx[p] == '0) begin
				read_data[p] = '0; // x0
			end
		end
	end

endmodule

// ==== result_stage.sv ====
// result stage holding the executed group
// raises the register writes and reports the commit count and error status

module result_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  superscalar_pkg::result_lane_t  executed [superscalar_pkg::WAYS],
	input  logic                           executed_valid,
	output superscalar_pkg::result_lane_t  retire   [superscalar_pkg::WAYS],
	output logic                           commit_valid,
	output superscalar_pkg::commit_lane_t  commit   [superscalar_pkg::WAYS],
	output superscalar_pkg::lane_count_t   completed_insts,
	output superscalar_pkg::error_status_t error_status
);

	superscalar_pkg::result_lane_t res_q [superscalar_pkg::WAYS];
	logic                          res_valid;
	logic [superscalar_pkg::WAYS-1:0] live;

	always_ff @(posedge clock) begin
		if (!reset) begin
			res_valid <= 1'b0;
			for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
				res_q[i].valid <= 1'b0;
			end
		end else begin
			res_valid <= executed_valid;
			res_q     <= executed;
		end
	end

	assign retire       = res_q; // also the forwarding source
	assign commit_valid = res_valid;

	always_comb begin
		superscalar_pkg::lane_count_t count;
		logic any_illegal;
		logic any_halt;
		count       = '0;
		any_illegal = 1'b0;
		any_halt    = 1'b0;
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			live[i] = res_q[i].valid; // bubble groups carry no valid lanes

			commit[i].wr_en = live[i] && res_q[i].writes_dest && !res_q[i].halt
				&& !res_q[i].illegal;
			commit[i].idx   = res_q[i].dest;
			commit[i].data  = res_q[i].result;

			count       = count + superscalar_pkg::lane_count_t'(live[i]); // wfi and illegal too
			any_illegal = any_illegal | (live[i] & res_q[i].illegal);
			any_halt    = any_halt | (live[i] & res_q[i].halt);
		end
		completed_insts = count;

		// illegal beats wfi
		if (any_illegal) begin
			error_status = superscalar_pkg::ILLEGAL_INST;
		end else if (any_halt) begin
			error_status = superscalar_pkg::HALTED_ON_WFI;
		end else begin
			error_status = superscalar_pkg::NO_ERROR;
		end
	end

endmodule

// ==== superscalar_core.sv ====
// three-lane integer pipeline core
// decode, execute and result stages around a shared register file

module superscalar_core (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           fetch_valid,
	input  superscalar_pkg::fetch_group_t  fetch_group,
	output logic                           commit_valid,
	output superscalar_pkg::commit_lane_t  commit [superscalar_pkg::WAYS],
	output superscalar_pkg::lane_count_t   completed_insts,
	output superscalar_pkg::error_status_t error_status
);

	superscalar_pkg::decoded_lane_t decoded  [superscalar_pkg::WAYS];
	logic                           decoded_valid;
	superscalar_pkg::result_lane_t  executed [superscalar_pkg::WAYS];
	logic                           executed_valid;
	superscalar_pkg::result_lane_t  retire   [superscalar_pkg::WAYS];

	superscalar_pkg::reg_idx_t read_idx  [superscalar_pkg::READ_PORTS];
	superscalar_pkg::word_t    read_data [superscalar_pkg::READ_PORTS];

	// write ports come straight off the commit lanes
	logic                      rf_write_en   [superscalar_pkg::WAYS];
	superscalar_pkg::reg_idx_t rf_write_idx  [superscalar_pkg::WAYS];
	superscalar_pkg::word_t    rf_write_data [superscalar_pkg::WAYS];

	always_comb begin
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			rf_write_en[i]   = commit[i].wr_en;
			rf_write_idx[i]  = commit[i].idx;
			rf_write_data[i] = commit[i].data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////////////////////

	decode_stage decode_stage_inst (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_group   (fetch_group),
		.read_data     (read_data),
		.read_idx      (read_idx),
		.decoded       (decoded),
		.decoded_valid (decoded_valid)
	);

	execute_stage execute_stage_inst (
		.clock          (clock),
		.reset          (reset),
		.decoded        (decoded),
		.decoded_valid  (decoded_valid),
		.retire         (retire),
		.executed       (executed),
		.executed_valid (executed_valid)
	);

	result_stage result_stage_inst (
		.clock           (clock),
		.reset           (reset),
		.executed        (executed),
		.executed_valid  (executed_valid),
		.retire          (retire),
		.commit_valid    (commit_valid),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	register_file register_file_inst (
		.clock      (clock),
		.reset      (reset),
		.write_en   (rf_write_en),
		.write_idx  (rf_write_idx),
		.write_data (rf_write_data),
		.read_idx   (read_idx),
		.read_data  (read_data)
	);

endmodule

// ==== superscalar_core_properties.sv ====
// commit-side assertions for the three-lane core bound to the top level

module superscalar_core_properties (
	input logic                          clock,
	input logic                          reset,
	input logic                          fetch_valid,
	input logic                          commit_valid,
	input superscalar_pkg::commit_lane_t commit [superscalar_pkg::WAYS],
	input superscalar_pkg::lane_count_t  completed_insts
);
	timeunit 1ns;
	timeprecision 100ps;

	// three stage registers between strobe and commit, reset held off meanwhile
	commit_follows_fetch: assert property (@(posedge clock)
		$past(reset, 1) && $past(reset, 2) && $past(reset, 3)
		|-> commit_valid == $past(fetch_valid, 3))
		else $error("commit_valid does not follow fetch_valid by three cycles");

	for (genvar i = 0; i < superscalar_pkg::WAYS; i++) begin : lane_checks
		no_x0_write: assert property (@(posedge clock) disable iff (!reset)
			!(commit[i].wr_en && commit[i].idx == '0))
			else $error("commit lane %0d enabled with index x0", i);
	end

	idle_count_zero: assert property (@(posedge clock) disable iff (!reset)
		!commit_valid |-> completed_insts == '0)
		else $error("completed_insts is nonzero with no commit");

endmodule

bind superscalar_core superscalar_core_properties superscalar_core_properties_inst (
	.clock           (clock),
	.reset           (reset),
	.fetch_valid     (fetch_valid),
	.commit_valid    (commit_valid),
	.commit          (commit),
	.completed_insts (completed_insts)
);

// ==== superscalar_core_tb.sv ====
// directed testbench for the three-lane core
// a sequential reference model predicts each commit, checked every falling edge

module superscalar_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int GROUP_TOTAL = 51; // 1 + 4 + 2 + 4 + 40
	localparam int TEST_TOTAL  = 6;
	localparam int CYCLE_LIMIT = GROUP_TOTAL + 3 * TEST_TOTAL + 50;

	typedef enum logic [3:0] {
		K_ADD,
		K_SUB,
		K_AND,
		K_OR,
		K_XOR,
		K_ADDI,
		K_LUI,
		K_WFI,
		K_BAD // a load encoding the core does not decode
	} kind_t;

	typedef struct packed {
		kind_t                     kind;
		superscalar_pkg::reg_idx_t rd;
		superscalar_pkg::reg_idx_t rs1;
		superscalar_pkg::reg_idx_t rs2;
		superscalar_pkg::word_t    imm;
	} op_t;

	typedef struct packed {
		op_t [superscalar_pkg::WAYS-1:0]  ops;
		logic [superscalar_pkg::WAYS-1:0] mask;
	} group_t;

	typedef struct packed {
		logic                                            valid;
		superscalar_pkg::commit_lane_t [superscalar_pkg::WAYS-1:0] lanes;
		superscalar_pkg::lane_count_t                    count;
		superscalar_pkg::error_status_t                  status;
	} expect_t;

	logic                           clock;
	logic                           reset;
	logic                           fetch_valid;
	superscalar_pkg::fetch_group_t  fetch_group;
	logic                           commit_valid;
	superscalar_pkg::commit_lane_t  commit [superscalar_pkg::WAYS];
	superscalar_pkg::lane_count_t   completed_insts;
	superscalar_pkg::error_status_t error_status;

	superscalar_pkg::word_t model_regs [superscalar_pkg::REG_COUNT];
	expect_t expect_q [$]; // one entry per cycle and three deep
	string   current_test;
	int      error_count = 0;
	int      checks_run = 0;
	int      test_count = 0;
	int      test_errors = 0;
	int      cycle_count = 0;
	int      seed;

	superscalar_core superscalar_core_inst (
		.clock           (clock),
		.reset           (reset),
		.fetch_valid     (fetch_valid),
		.fetch_group     (fetch_group),
		.commit_valid    (commit_valid),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("run stopped: no finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// encoding and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic superscalar_pkg::inst_t encode(input op_t op);
		case (op.kind)
			K_ADD:  return {7'b0000000, op.rs2, op.rs1, 3'b000, op.rd, superscalar_pkg::OPCODE_OP};
			K_SUB:  return {7'b0100000, op.rs2, op.rs1, 3'b000, op.rd, superscalar_pkg::OPCODE_OP};
			K_AND:  return {7'b0000000, op.rs2, op.rs1, 3'b111, op.rd, superscalar_pkg::OPCODE_OP};
			K_OR:   return {7'b0000000, op.rs2, op.rs1, 3'b110, op.rd, superscalar_pkg::OPCODE_OP};
			K_XOR:  return {7'b0000000, op.rs2, op.rs1, 3'b100, op.rd, superscalar_pkg::OPCODE_OP};
			K_ADDI: return {op.imm[11:0], op.rs1, 3'b000, op.rd, superscalar_pkg::OPCODE_OP_IMM};
			K_LUI:  return {op.imm[31:12], op.rd, superscalar_pkg::OPCODE_LUI};
			K_WFI:  return superscalar_pkg::INST_WFI;
			default: return {op.imm[11:0], op.rs1, 3'b010, op.rd, 7'b0000011}; // lw
		endcase
	endfunction

	function automatic superscalar_pkg::fetch_group_t encode_group(input group_t g);
		superscalar_pkg::fetch_group_t fg;
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			fg.inst[i] = encode(g.ops[i]);
		end
		fg.mask = g.mask;
		return fg;
	endfunction

	function automatic op_t make_op(input kind_t k, input int rd, input int rs1, input int rs2,
			input superscalar_pkg::word_t imm);
		op_t op;
		op.kind = k;
		op.rd   = superscalar_pkg::reg_idx_t'(rd);
		op.rs1  = superscalar_pkg::reg_idx_t'(rs1);
		op.rs2  = superscalar_pkg::reg_idx_t'(rs2);
		op.imm  = imm;
		return op;
	endfunction

	function automatic group_t make_group(input logic [2:0] mask, input op_t l0, input op_t l1,
			input op_t l2);
		group_t g;
		g.ops[0] = l0;
		g.ops[1] = l1;
		g.ops[2] = l2;
		g.mask   = mask;
		return g;
	endfunction

	function automatic expect_t idle_expect();
		expect_t e;
		e        = '0;
		e.status = superscalar_pkg::NO_ERROR;
		return e;
	endfunction

	// lanes run in program order and each sees every earlier write
	function automatic expect_t model_group(input group_t g);
		expect_t                e;
		superscalar_pkg::word_t a;
		superscalar_pkg::word_t b;
		superscalar_pkg::word_t result;
		logic                   writes;
		logic                   any_bad;
		logic                   any_wfi;
		e       = idle_expect();
		e.valid = 1'b1;
		any_bad = 1'b0;
		any_wfi = 1'b0;
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			if (g.mask[i]) begin
				a      = model_regs[g.ops[i].rs1];
				b      = model_regs[g.ops[i].rs2];
				writes = 1'b1;
				case (g.ops[i].kind)
					K_ADD:  result = a + b;
					K_SUB:  result = a - b;
					K_AND:  result = a & b;
					K_OR:   result = a | b;
					K_XOR:  result = a ^ b;
					K_ADDI: result = a + {{20{g.ops[i].imm[11]}}, g.ops[i].imm[11:0]};
					K_LUI:  result = {g.ops[i].imm[31:12], 12'b0};
					K_WFI: begin
						result  = '0;
						writes  = 1'b0;
						any_wfi = 1'b1;
					end
					default: begin
						result  = '0;
						writes  = 1'b0;
						any_bad = 1'b1;
					end
				endcase
				if (g.ops[i].rd == '0) begin
					writes = 1'b0;
				end
				if (writes) begin
					model_regs[g.ops[i].rd] = result;
				end
				e.lanes[i].wr_en = writes;
				e.lanes[i].idx   = g.ops[i].rd;
				e.lanes[i].data  = result;
				e.count          = e.count + 2'd1; // wfi and illegal count too
			end
		end
		if (any_bad) begin
			e.status = superscalar_pkg::ILLEGAL_INST;
		end else if (any_wfi) begin
			e.status = superscalar_pkg::HALTED_ON_WFI;
		end else begin
			e.status = superscalar_pkg::NO_ERROR;
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_commit(input int lane, input superscalar_pkg::commit_lane_t exp,
			input superscalar_pkg::commit_lane_t act);
		checks_run++;
		// idx and data only matter on an enabled lane
		if (exp.wr_en ? (act !== exp) : (act.wr_en !== 1'b0)) begin
			error_count++;
			$display("Fail %s lane %0d commit: expected en=%b x%0d=%h, actual en=%b x%0d=%h",
				current_test, lane, exp.wr_en, exp.idx, exp.data, act.wr_en, act.idx, act.data);
		end
	endtask

	task automatic check_count(input superscalar_pkg::lane_count_t exp,
			input superscalar_pkg::lane_count_t act);
		checks_run++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s count: expected %0d, actual %0d", current_test, exp, act);
		end
	endtask

	task automatic check_status(input superscalar_pkg::error_status_t exp,
			input superscalar_pkg::error_status_t act);
		checks_run++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s status: expected %s, actual %s", current_test, exp.name(),
				act.name());
		end
	endtask

	task automatic check_cycle(input expect_t due);
		checks_run++;
		if (due.valid && commit_valid !== 1'b1) begin
			error_count++;
			$display("%s: the commit did not arrive in the cycle after E+2", current_test);
		end else if (!due.valid && commit_valid !== 1'b0) begin
			error_count++;
			$display("%s: a commit showed up with no group due", current_test);
		end
		for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
			check_commit(i, due.lanes[i], commit[i]);
		end
		check_count(due.count, completed_insts);
		check_status(due.status, error_status);
	endtask

	// on each falling edge check what is due and then drive the next group
	task automatic step(input logic valid, input group_t g);
		expect_t due;
		@(negedge clock);
		due = expect_q.pop_front();
		check_cycle(due);
		fetch_valid = valid;
		fetch_group = encode_group(g);
		if (valid) begin
			expect_q.push_back(model_group(g));
		end else begin
			expect_q.push_back(idle_expect());
		end
	endtask

	task automatic drive_group(input group_t g);
		step(1'b1, g);
	endtask

	task automatic idle_cycle();
		step(1'b0, '0);
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = error_count;
		test_count++;
	endtask

	task automatic finish_test();
		repeat (3) idle_cycle(); // drain the pipe
		$display("test %s done, %0d errors", current_test, error_count - test_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		start_test("reset_idle");
		finish_test();
	endtask

	task automatic independent_lanes();
		start_test("independent_lanes");
		drive_group(make_group(3'b111, make_op(K_LUI, 1, 0, 0, 32'h1234_5000),
			make_op(K_ADDI, 2, 0, 0, 32'h7f), make_op(K_XOR, 3, 4, 5, 0)));
		finish_test();
	endtask

	task automatic back_to_back();
		start_test("back_to_back");
		drive_group(make_group(3'b111, make_op(K_ADDI, 4, 1, 0, 1),
			make_op(K_ADDI, 5, 2, 0, 2), make_op(K_SUB, 6, 1, 2, 0)));
		drive_group(make_group(3'b111, make_op(K_ADD, 7, 4, 5, 0),
			make_op(K_OR, 8, 6, 1, 0), make_op(K_AND, 9, 4, 2, 0)));
		// x4 now comes through the register file write-through
		drive_group(make_group(3'b111, make_op(K_XOR, 10, 4, 7, 0),
			make_op(K_ADD, 11, 8, 5, 0), make_op(K_SUB, 12, 9, 6, 0)));
		drive_group(make_group(3'b111, make_op(K_ADD, 13, 10, 11, 0),
			make_op(K_ADD, 14, 7, 12, 0), make_op(K_ADDI, 15, 13, 0, 32'hffff_ffff)));
		finish_test();
	endtask

	task automatic intra_group_mask();
		start_test("intra_group_mask");
		drive_group(make_group(3'b111, make_op(K_ADDI, 16, 0, 0, 100),
			make_op(K_ADD, 17, 16, 16, 0), make_op(K_ADDI, 16, 17, 0, 5)));
		drive_group(make_group(3'b101, make_op(K_ADD, 18, 16, 17, 0),
			make_op(K_ADDI, 19, 0, 0, 55), make_op(K_SUB, 20, 18, 16, 0)));
		finish_test();
	endtask

	task automatic status_suppression();
		start_test("status_suppression");
		drive_group(make_group(3'b111, make_op(K_ADDI, 21, 0, 0, 7),
			make_op(K_BAD, 22, 21, 0, 0), make_op(K_WFI, 0, 0, 0, 0)));
		drive_group(make_group(3'b111, make_op(K_ADDI, 24, 0, 0, 9),
			make_op(K_WFI, 0, 0, 0, 0), make_op(K_ADD, 25, 24, 21, 0)));
		drive_group(make_group(3'b111, make_op(K_ADDI, 0, 21, 0, 3),
			make_op(K_ADD, 0, 21, 21, 0), make_op(K_LUI, 26, 0, 0, 32'habcd_e000)));
		drive_group(make_group(3'b111, make_op(K_ADD, 27, 0, 21, 0),
			make_op(K_ADDI, 28, 0, 0, 0), make_op(K_OR, 29, 0, 0, 0)));
		finish_test();
	endtask

	task automatic random_stream();
		group_t g;
		int     rnd;
		start_test("random_stream");
		for (int n = 0; n < 40; n++) begin
			for (int i = 0; i < superscalar_pkg::WAYS; i++) begin
				g.ops[i].kind = kind_t'($unsigned($random(seed)) % 7); // alu kinds only
				g.ops[i].rd   = superscalar_pkg::reg_idx_t'($random(seed));
				g.ops[i].rs1  = superscalar_pkg::reg_idx_t'($random(seed));
				g.ops[i].rs2  = superscalar_pkg::reg_idx_t'($random(seed));
				g.ops[i].imm  = $random(seed);
			end
			rnd    = $random(seed);
			g.mask = rnd[superscalar_pkg::WAYS-1:0];
			drive_group(g);
		end
		finish_test();
	endtask

	initial begin
		seed        = 32'had019594;
		reset       = 1'b0;
		fetch_valid = 1'b0;
		fetch_group = '0;
		for (int r = 0; r < superscalar_pkg::REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		repeat (3) expect_q.push_back(idle_expect());

		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;

		idle_after_reset();
		independent_lanes();
		back_to_back();
		intra_group_mask();
		status_suppression();
		random_stream();

		$display("tests %0d, checks %0d, errors %0d", test_count, checks_run, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== superscalar_pkg.sv ====
// superscalar core shared definitions
// widths, RV32I encodings, ALU and status enums, per-stage lane structs

package superscalar_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int WAYS       = 3;        // lanes per fetch group
	localparam int REG_COUNT  = 32;
	localparam int READ_PORTS = 2 * WAYS; // rs1 and rs2 per lane

	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
	typedef logic [XLEN-1:0]              word_t;
	typedef logic [31:0]                  inst_t;
	typedef logic [1:0]                   lane_count_t;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

	localparam inst_t INST_WFI = 32'h1050_0073;
	localparam inst_t INST_NOP = 32'h0000_0013; // addi x0, x0, 0

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B // lui
	} alu_op_t;

	typedef enum logic [1:0] {
		NO_ERROR,
		HALTED_ON_WFI,
		ILLEGAL_INST
	} error_status_t;

	////////////////////////////////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		inst_t [WAYS-1:0] inst;
		logic  [WAYS-1:0] mask; // lane valid
	} fetch_group_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    rs1_value;
		word_t    rs2_value;
		word_t    imm;
		logic     use_imm;
		alu_op_t  alu_op;
		reg_idx_t dest;
		logic     writes_dest;
		logic     halt;
		logic     illegal;
	} decoded_lane_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		logic     writes_dest;
		word_t    result;
		logic     halt;
		logic     illegal;
	} result_lane_t;

	typedef struct packed {
		logic     wr_en;
		reg_idx_t idx;
		word_t    data;
	} commit_lane_t;

endpackage
